// ==== alu8.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu8
  import cpu_pkg::*;
  import isa_pkg::*;
(
  input  exec_t exec,
  input  byte_t a,
  input  byte_t b,
  input  cc_t   cc,
  output byte_t alu_result,
  output cc_t   alu_cc,                      // Equals cc when no op matched
  output logic  alu_write
);

  byte_t       acc;                          // Selected accumulator
  byte_t       opnd;                         // Immediate byte
  logic  [8:0] sum;                          // Carry out in bit 8
  logic  [8:0] diff;                         // Borrow out in bit 8
  logic        imm_op;
  logic        inh_op;
  logic        hit;                          // Kept operation decoded
  logic        keep;                         // Result goes back to A/B
  logic        h_n, v_n, c_n;

  assign imm_op = exec.is_imm &&
                  (exec.opcode[7:4] == OPC_SUBA[7:4] || exec.opcode[7:4] == OPC_SUBB[7:4]);
  assign inh_op = !exec.is_imm &&
                  (exec.opcode[7:4] == OPC_NEGA[7:4] || exec.opcode[7:4] == OPC_NEGB[7:4]);
  assign acc    = acc_is_b(exec.opcode, exec.is_imm) ? b : a;
  assign opnd   = exec.operand[7:0];
  assign sum    = {1'b0, acc} + {1'b0, opnd} +
                  {8'h00, cc.c & (exec.opcode[3:0] == ALU_OP_ADC)};
  assign diff   = {1'b0, acc} - {1'b0, opnd};

  always_comb begin
    alu_result = acc;
    h_n        = cc.h;                       // H only moves on adds
    v_n        = 1'b0;
    c_n        = cc.c;
    hit        = 1'b1;
    keep       = 1'b1;
    if (imm_op) begin
      case (exec.opcode[3:0])
        ALU_OP_SUB, ALU_OP_CMP: begin
          alu_result = diff[7:0];
          c_n        = diff[8];
          v_n        = (acc[7] ^ opnd[7]) & (acc[7] ^ diff[7]);
          keep       = (exec.opcode[3:0] == ALU_OP_SUB);   // CMP sets flags only
        end
        ALU_OP_AND: alu_result = acc & opnd;
        ALU_OP_LD:  alu_result = opnd;
        ALU_OP_EOR: alu_result = acc ^ opnd;
        ALU_OP_OR:  alu_result = acc | opnd;
        ALU_OP_ADC, ALU_OP_ADD: begin
          alu_result = sum[7:0];
          c_n        = sum[8];
          h_n        = acc[4] ^ opnd[4] ^ sum[4];          // Carry into bit 4
          v_n        = (acc[7] ~^ opnd[7]) & (acc[7] ^ sum[7]);
        end
        default: hit = 1'b0;
      endcase
    end else if (inh_op) begin
      case (exec.opcode[3:0])
        ALU_OP_NEG: begin
          alu_result = 8'h00 - acc;
          c_n        = (acc != 8'h00);
          v_n        = (acc == 8'h80);
        end
        ALU_OP_COM: begin
          alu_result = ~acc;
          c_n        = 1'b1;
        end
        ALU_OP_LSR: begin
          alu_result = {1'b0, acc[7:1]};     // N ends up clear
          c_n        = acc[0];
        end
        ALU_OP_ASL: begin
          alu_result = {acc[6:0], 1'b0};
          c_n        = acc[7];
          v_n        = acc[7] ^ acc[6];      // N xor C
        end
        ALU_OP_DEC: begin
          alu_result = acc - 8'd1;
          v_n        = (acc == 8'h80);
        end
        ALU_OP_INC: begin
          alu_result = acc + 8'd1;
          v_n        = (acc == 8'h7F);
        end
        ALU_OP_TST: keep = 1'b0;
        ALU_OP_CLR: begin
          alu_result = 8'h00;
          c_n        = 1'b0;
        end
        default: hit = 1'b0;
      endcase
    end else begin
      hit = 1'b0;                            // Branches, 16-bit loads, no-ops
    end
  end

  assign alu_cc    = hit ? cc_t'{e: cc.e, f: cc.f, h: h_n, i: cc.i, n: alu_result[7],
                                 z: (alu_result == 8'h00), v: v_n, c: c_n} : cc;
  assign alu_write = exec.valid && hit && keep;

endmodule

`default_nettype wire

// ==== core6809_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module core6809_top
  import cpu_pkg::*;
  import isa_pkg::*;
(
  input  logic  clk,
  input  logic  reset_b,
  input  byte_t din,                         // mem[addr], read only
  output addr_t addr
);

  // --------------------------------------------------------------------------
  // Vector fetch
  // --------------------------------------------------------------------------
  logic  vec_busy;
  addr_t vec_addr;
  logic  vec_load;
  word_t vec_word;

  // Fetch to execute
  exec_t exec;
  logic  branch_fetch;

  // Registers and ALU
  byte_t a;
  byte_t b;
  cc_t   cc;
  byte_t alu_result;
  cc_t   alu_cc;
  logic  alu_write;

  // All ports share the names of the nets above
  reset_vector_seq u_reset_vector_seq (.*);
  fetch_ctrl       u_fetch_ctrl       (.*);
  alu8             u_alu8             (.*);
  reg_file         u_reg_file         (.*);
  pc_unit          u_pc_unit          (.*);

endmodule

`default_nettype wire

// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  localparam int BYTE_W = 8;                 // Data bus width
  localparam int WORD_W = 16;                // Register pair and address width

  typedef logic [BYTE_W-1:0] byte_t;         // Data byte
  typedef logic [WORD_W-1:0] word_t;         // 16-bit register value
  typedef logic [WORD_W-1:0] addr_t;         // Bus address

  // Condition code register, msb first
  typedef struct packed {
    logic e;                                 // Entire state stacked
    logic f;                                 // FIRQ mask
    logic h;                                 // Half carry
    logic i;                                 // IRQ mask
    logic n;                                 // Negative
    logic z;                                 // Zero
    logic v;                                 // Overflow
    logic c;                                 // Carry / borrow
  } cc_t;

  localparam cc_t   CC_RESET          = 8'b1101_0000;   // E, F and I set out of reset
  localparam addr_t RESET_VECTOR_ADDR = 16'hFFFE;        // High byte, low byte at FFFF

endpackage

`default_nettype wire

// ==== fetch_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_ctrl
  import cpu_pkg::*;
  import isa_pkg::*;
(
  input  logic  clk,
  input  logic  reset_b,
  input  byte_t din,
  input  logic  vec_load,
  output exec_t exec,
  output logic  branch_fetch                 // Branch offset on din
);

  fetch_state_e state_q, state_d;
  fetch_class_e class_q, class_d;            // class_d sorts din in FETCH_IR
  byte_t        ir_q;                        // Opcode
  byte_t        pb_q;                        // Post-byte / immediate
  byte_t        b2_q;                        // Low byte of a 16-bit immediate
  logic         valid_q;
  logic         last_byte;                   // Instruction complete at this edge

  // --------------------------------------------------------------------------
  // Fetch classifier, straight off the bus
  // --------------------------------------------------------------------------
  always_comb begin
    class_d = FC_INH;                        // Unknown opcodes run as 1-byte no-ops
    if (din[7:4] == OPC_BRA[7:4]) begin
      class_d = FC_IMM8;
    end else if ((din[7:4] == OPC_SUBA[7:4] || din[7:4] == OPC_SUBB[7:4]) &&
                 din[3:0] inside {ALU_OP_SUB, ALU_OP_CMP, ALU_OP_AND, ALU_OP_LD,
                                  ALU_OP_EOR, ALU_OP_ADC, ALU_OP_OR, ALU_OP_ADD}) begin
      class_d = FC_IMM8;
    end else if (din inside {OPC_LDD, OPC_LDX, OPC_LDU}) begin
      class_d = FC_IMM16;
    end
  end

  always_comb begin
    state_d   = state_q;
    last_byte = 1'b0;
    case (state_q)
      FETCH_WAIT: begin
        if (vec_load) state_d = FETCH_IR;
      end
      FETCH_IR: begin
        last_byte = (class_d == FC_INH);
        state_d   = last_byte ? FETCH_IR : FETCH_PB;
      end
      FETCH_PB: begin
        last_byte = (class_q != FC_IMM16);
        state_d   = last_byte ? FETCH_IR : FETCH_B2;
      end
      FETCH_B2, FETCH_B3: begin
        last_byte = 1'b1;
        state_d   = FETCH_IR;
      end
      default: state_d = FETCH_WAIT;
    endcase
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state_q <= FETCH_WAIT;
      class_q <= FC_INH;
      ir_q    <= '0;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      valid_q <= last_byte;                  // Strobe follows the last byte
      if (state_q == FETCH_IR) begin
        ir_q    <= din;
        class_q <= class_d;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == FETCH_PB) pb_q <= din;
    if (state_q == FETCH_B2) b2_q <= din;
  end

  always_comb begin
    exec.valid   = valid_q;
    exec.opcode  = ir_q;
    exec.operand = (class_q == FC_IMM16) ? {pb_q, b2_q} : {8'h00, pb_q};
    exec.is_imm  = (class_q != FC_INH);
    exec.is_ld16 = (class_q == FC_IMM16);    // Only LDD, LDX, LDU get here
  end

  assign branch_fetch = (state_q == FETCH_PB) && (ir_q[7:4] == OPC_BRA[7:4]);

  a_state_onehot: assert property (@(posedge clk) disable iff (!reset_b)
    $onehot(state_q));

  // Back-to-back strobes only with a fresh opcode captured in between
  a_exec_new_op: assert property (@(posedge clk) disable iff (!reset_b)
    exec.valid && $past(exec.valid) |-> $past(state_q) == FETCH_IR);

endmodule

`default_nettype wire

// ==== isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  import cpu_pkg::*;

  // --------------------------------------------------------------------------
  // Opcodes
  // --------------------------------------------------------------------------
  // Row bases, only the high nibble is compared
  localparam byte_t OPC_BRA  = 8'h20;        // Short branches, condition in low nibble
  localparam byte_t OPC_NEGA = 8'h40;        // Inherent row on A
  localparam byte_t OPC_NEGB = 8'h50;        // Inherent row on B
  localparam byte_t OPC_SUBA = 8'h80;        // Immediate row on A
  localparam byte_t OPC_SUBB = 8'hC0;        // Immediate row on B
  localparam byte_t OPC_LDX  = 8'h8E;
  localparam byte_t OPC_LDD  = 8'hCC;
  localparam byte_t OPC_LDU  = 8'hCE;

  // Low nibble in the immediate rows
  localparam logic [3:0] ALU_OP_SUB = 4'h0;
  localparam logic [3:0] ALU_OP_CMP = 4'h1;
  localparam logic [3:0] ALU_OP_AND = 4'h4;
  localparam logic [3:0] ALU_OP_LD  = 4'h6;
  localparam logic [3:0] ALU_OP_EOR = 4'h8;
  localparam logic [3:0] ALU_OP_ADC = 4'h9;
  localparam logic [3:0] ALU_OP_OR  = 4'hA;
  localparam logic [3:0] ALU_OP_ADD = 4'hB;

  // Low nibble in the inherent rows
  localparam logic [3:0] ALU_OP_NEG = 4'h0;
  localparam logic [3:0] ALU_OP_COM = 4'h3;
  localparam logic [3:0] ALU_OP_LSR = 4'h4;
  localparam logic [3:0] ALU_OP_ASL = 4'h8;
  localparam logic [3:0] ALU_OP_DEC = 4'hA;
  localparam logic [3:0] ALU_OP_INC = 4'hC;
  localparam logic [3:0] ALU_OP_TST = 4'hD;
  localparam logic [3:0] ALU_OP_CLR = 4'hF;

  // One-hot fetch state
  typedef enum logic [4:0] {
    FETCH_WAIT = 5'b0_0001,                  // Waiting on the reset vector
    FETCH_IR   = 5'b0_0010,                  // Opcode on the bus
    FETCH_PB   = 5'b0_0100,                  // Post-byte or first immediate byte
    FETCH_B2   = 5'b0_1000,                  // Second immediate byte
    FETCH_B3   = 5'b1_0000                   // Reserved for 4-byte forms
  } fetch_state_e;

  typedef enum logic [1:0] {FC_INH, FC_IMM8, FC_IMM16} fetch_class_e;

  typedef struct packed {
    logic  valid;                            // Execute strobe
    byte_t opcode;
    word_t operand;                          // Immediate byte in [7:0] or full word
    logic  is_imm;
    logic  is_ld16;
  } exec_t;

  // B sits in the C row (bit 6) and in the 5 row (bit 4)
  function automatic logic acc_is_b(byte_t opcode, logic is_imm);
    return is_imm ? opcode[6] : opcode[4];
  endfunction

endpackage

`default_nettype wire

// ==== pc_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module pc_unit
  import cpu_pkg::*;
  import isa_pkg::*;
(
  input  logic  clk,
  input  logic  reset_b,
  input  byte_t din,                         // Branch offset when branch_fetch
  input  logic  vec_busy,
  input  addr_t vec_addr,
  input  logic  vec_load,
  input  word_t vec_word,
  input  logic  branch_fetch,
  input  exec_t exec,
  input  cc_t   cc,
  output addr_t addr
);

  addr_t pc_q;                               // Address of the byte on the bus
  addr_t pc_inc;
  logic  pc_step;                            // PC moves this cycle
  logic  taken;

  assign pc_step = !vec_busy;
  assign pc_inc  = pc_q + 16'd1;

  // Condition from the low opcode nibble
  always_comb begin
    case (exec.opcode[3:0])
      4'h0:    taken = 1'b1;                 // BRA
      4'h4:    taken = !cc.c;                // BCC
      4'h5:    taken = cc.c;                 // BCS
      4'h6:    taken = !cc.z;                // BNE
      4'h7:    taken = cc.z;                 // BEQ
      4'h8:    taken = !cc.v;                // BVC
      4'h9:    taken = cc.v;                 // BVS
      4'hA:    taken = !cc.n;                // BPL
      4'hB:    taken = cc.n;                 // BMI
      default: taken = 1'b0;                 // BRN and unsupported conditions
    endcase
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      pc_q <= '0;
    end else if (vec_load) begin
      pc_q <= vec_word;
    end else if (pc_step) begin
      pc_q <= (branch_fetch && taken) ? pc_inc + {{8{din[7]}}, din} : pc_inc;
    end
  end

  assign addr = vec_busy ? vec_addr : pc_q;  // Vector fetch first

  a_pc_hold: assert property (@(posedge clk) disable iff (!reset_b)
    vec_busy && !vec_load |=> $stable(pc_q));

  // Offset cycle never overlaps an execute, so the flags are settled
  a_branch_cc: assert property (@(posedge clk) disable iff (!reset_b)
    branch_fetch |-> !exec.valid);

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file
  import cpu_pkg::*;
  import isa_pkg::*;
(
  input  logic  clk,
  input  logic  reset_b,
  input  exec_t exec,
  input  byte_t alu_result,
  input  cc_t   alu_cc,
  input  logic  alu_write,
  output byte_t a,
  output byte_t b,
  output cc_t   cc
);

  word_t x_q;                                // Index register, for later addressing modes
  word_t u_q;                                // User stack pointer, same
  cc_t   ld16_cc;

  // 16-bit load flags
  always_comb begin
    ld16_cc   = cc;                          // C, H and masks kept
    ld16_cc.n = exec.operand[15];
    ld16_cc.z = (exec.operand == 16'h0000);
    ld16_cc.v = 1'b0;
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      a   <= '0;
      b   <= '0;
      x_q <= '0;
      u_q <= '0;
      cc  <= CC_RESET;
    end else if (exec.valid) begin
      if (exec.is_ld16) begin
        cc <= ld16_cc;
        case (exec.opcode)
          OPC_LDD: {a, b} <= exec.operand;   // D is A:B
          OPC_LDX: x_q    <= exec.operand;
          OPC_LDU: u_q    <= exec.operand;
          default: ;
        endcase
      end else begin
        cc <= alu_cc;                        // Unchanged for branches and no-ops
        if (alu_write) begin
          if (acc_is_b(exec.opcode, exec.is_imm)) begin
            b <= alu_result;
          end else begin
            a <= alu_result;
          end
        end
      end
    end
  end

  // ALU write-back only in an execute cycle and never with a 16-bit load
  a_alu_write: assert property (@(posedge clk) disable iff (!reset_b)
    alu_write |-> exec.valid && !exec.is_ld16);

endmodule

`default_nettype wire

// ==== reset_vector_seq.sv ====
`timescale 1ns/100ps
`default_nettype none

module reset_vector_seq
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  reset_b,
  input  byte_t din,
  output logic  vec_busy,                    // Sequencer owns the address bus
  output addr_t vec_addr,
  output logic  vec_load,                    // Low byte on din this cycle
  output word_t vec_word
);

  byte_t hi_q;                               // Staged high byte
  logic  step_q;                             // Second step, low byte

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      vec_busy <= 1'b1;
      vec_addr <= RESET_VECTOR_ADDR;
      step_q   <= 1'b0;
    end else if (vec_busy) begin
      step_q <= 1'b1;
      if (step_q) begin
        vec_busy <= 1'b0;                    // Idle until the next reset
      end else begin
        vec_addr <= vec_addr + 16'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (vec_busy && !step_q) begin
      hi_q <= din;
    end
  end

  assign vec_load = vec_busy && step_q;
  assign vec_word = {hi_q, din};             // Big-endian

  // Single pulse, bus released right after it
  a_vec_load: assert property (@(posedge clk) disable iff (!reset_b)
    vec_load |-> vec_busy ##1 (!vec_busy && !vec_load));

endmodule

`default_nettype wire

// ==== tb.f ====
cpu_pkg.sv
isa_pkg.sv
reset_vector_seq.sv
fetch_ctrl.sv
alu8.sv
reg_file.sv
pc_unit.sv
core6809_top.sv
tb_core6809.sv

// ==== tb_core6809.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_core6809
  import cpu_pkg::*;
();

  localparam int          NUM_ROWS   = 21;
  localparam int          MAX_CYCLES = NUM_ROWS * (5 + 3 + 12) + 50;
  localparam int unsigned SEED       = 32'ha8d4_aad1;

  // One test program of up to three instructions and a branch
  typedef struct packed {
    addr_t       vector;                     // Reset vector and first opcode address
    logic [1:0]  n_ins;
    logic        rnd;                        // Immediates from $urandom
    byte_t [0:2] op;
    word_t [0:2] opd;
    byte_t       br_op;
    byte_t       br_off;
  } row_t;

  logic  clk;
  logic  reset_b;
  byte_t din;
  addr_t addr;

  byte_t mem [addr_t];                       // Sparse memory image
  int    errors    = 0;
  int    cycle_cnt = 0;

  // Reference machine state
  byte_t ref_a, ref_b;
  logic  ref_n, ref_z, ref_v, ref_c;

  row_t rows [NUM_ROWS] = '{
    '{16'h1000, 2'd0, 1'b0, '{0, 0, 0}, '{0, 0, 0}, 8'h20, 8'h04},           // BRA forward
    '{16'h1100, 2'd1, 1'b0, '{8'h12, 0, 0}, '{0, 0, 0}, 8'h21, 8'h10},       // Unknown op, BRN
    '{16'h1200, 2'd0, 1'b0, '{0, 0, 0}, '{0, 0, 0}, 8'h20, 8'hF0},           // BRA backward
    '{16'h1300, 2'd1, 1'b0, '{8'h86, 0, 0}, '{16'h0000, 0, 0}, 8'h26, 8'h06}, // LDA #0, BNE
    '{16'h1400, 2'd1, 1'b0, '{8'hC6, 0, 0}, '{16'h0080, 0, 0}, 8'h2B, 8'h06}, // LDB #80, BMI
    '{16'h1500, 2'd2, 1'b0, '{8'h86, 8'h8B, 0}, '{16'h7F, 16'h01, 0}, 8'h29, 8'h08},
    '{16'h1600, 2'd2, 1'b0, '{8'h86, 8'h80, 0}, '{16'h10, 16'h20, 0}, 8'h25, 8'h08},
    '{16'h1700, 2'd2, 1'b0, '{8'hC6, 8'hC1, 0}, '{16'h05, 16'h05, 0}, 8'h27, 8'hFA},
    '{16'h1800, 2'd2, 1'b0, '{8'h5F, 8'h5A, 0}, '{0, 0, 0}, 8'h2B, 8'h05},   // CLRB, DECB
    '{16'h1900, 2'd2, 1'b0, '{8'h86, 8'h4C, 0}, '{16'h7F, 0, 0}, 8'h29, 8'h07},
    '{16'h1A00, 2'd2, 1'b0, '{8'h86, 8'h40, 0}, '{16'h80, 0, 0}, 8'h29, 8'h07},
    '{16'h1B00, 2'd2, 1'b0, '{8'h86, 8'h48, 0}, '{16'hC0, 0, 0}, 8'h29, 8'h07},
    // COMB sets C and LSRA of 02 clears it again
    '{16'h1C00, 2'd3, 1'b0, '{8'h53, 8'h86, 8'h44}, '{0, 16'h02, 0}, 8'h25, 8'h06},
    '{16'h1D00, 2'd3, 1'b0, '{8'h86, 8'h8A, 8'h4D}, '{16'hAA, 16'h05, 0}, 8'h2B, 8'h05},
    '{16'h1E00, 2'd3, 1'b0, '{8'h86, 8'h8B, 8'h89}, '{16'hFF, 16'h01, 0}, 8'h24, 8'h05},
    '{16'h2000, 2'd1, 1'b0, '{8'hCC, 0, 0}, '{16'h8000, 0, 0}, 8'h2B, 8'h04}, // LDD, BMI
    '{16'h2100, 2'd1, 1'b0, '{8'h8E, 0, 0}, '{16'h0000, 0, 0}, 8'h27, 8'h04}, // LDX, BEQ
    // LDU clears the V left by the add
    '{16'h2200, 2'd3, 1'b0, '{8'h86, 8'h8B, 8'hCE}, '{16'h7F, 16'h01, 16'h1234}, 8'h28, 8'h04},
    '{16'h2300, 2'd2, 1'b1, '{8'h86, 8'h8B, 0}, '{0, 0, 0}, 8'h25, 8'h06},   // Random ADDA
    '{16'h2400, 2'd2, 1'b1, '{8'hC6, 8'hC0, 0}, '{0, 0, 0}, 8'h2B, 8'h06},   // Random SUBB
    '{16'h2500, 2'd3, 1'b1, '{8'h86, 8'h88, 8'h81}, '{0, 0, 0}, 8'h29, 8'h06}
  };

  core6809_top DUT (
    .clk     (clk),
    .reset_b (reset_b),
    .din     (din),
    .addr    (addr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic byte_t mem_read(input addr_t ad);
    return mem.exists(ad) ? mem[ad] : (ad[15:8] ^ ad[7:0]);   // Unwritten bytes follow the address
  endfunction

  // Combinational memory settled long before the next edge
  always @(posedge clk) begin
    #1;
    din = mem_read(addr);
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the test table did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors found");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  task automatic check_value(input logic [15:0] actual, input logic [15:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Errors found");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic wait_cycle();
    @(posedge clk);
    #1;
  endtask

  // Instruction length from the opcode map
  function automatic int ins_len(input byte_t op);
    if (op[7:4] == 4'h2) return 2;
    if (op[7:4] inside {4'h8, 4'hC} &&
        op[3:0] inside {4'h0, 4'h1, 4'h4, 4'h6, 4'h8, 4'h9, 4'hA, 4'hB}) return 2;
    if (op inside {8'h8E, 8'hCC, 8'hCE}) return 3;
    return 1;
  endfunction

  function automatic logic branch_taken(input logic [3:0] cond);
    case (cond)
      4'h0:    return 1'b1;
      4'h4:    return !ref_c;
      4'h5:    return ref_c;
      4'h6:    return !ref_z;
      4'h7:    return ref_z;
      4'h8:    return !ref_v;
      4'h9:    return ref_v;
      4'hA:    return !ref_n;
      4'hB:    return ref_n;
      default: return 1'b0;                  // BRN and the dropped conditions
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // Reference flag model
  // --------------------------------------------------------------------------
  function automatic void model_exec(input byte_t op, input word_t opd);
    byte_t acc;
    byte_t m;
    byte_t res;
    logic  cin;
    logic  wr;
    logic  hit;
    int    ud;
    int    sd;
    acc = (op[7:4] inside {4'hC, 4'h5}) ? ref_b : ref_a;
    m   = opd[7:0];
    res = acc;
    wr  = 1'b1;
    hit = 1'b1;
    cin = ref_c && (op[3:0] == 4'h9);        // Carry in for ADC only
    if (op inside {8'h8E, 8'hCC, 8'hCE}) begin
      ref_n = opd[15];
      ref_z = (opd == 16'h0000);
      ref_v = 1'b0;
      if (op == 8'hCC) begin
        ref_a = opd[15:8];                   // D is A:B
        ref_b = opd[7:0];
      end
      return;
    end
    if (op[7:4] inside {4'h8, 4'hC}) begin
      case (op[3:0])
        4'h0, 4'h1: begin                    // SUB, CMP
          res   = acc - m;
          sd    = $signed(acc) - $signed(m);
          ref_c = (m > acc);
          ref_v = (sd > 127) || (sd < -128);
          wr    = (op[3:0] == 4'h0);
        end
        4'h4, 4'h6, 4'h8, 4'hA: begin        // AND, LD, EOR, OR
          res   = (op[3:0] == 4'h4) ? (acc & m) : (op[3:0] == 4'h6) ? m :
                  (op[3:0] == 4'h8) ? (acc ^ m) : (acc | m);
          ref_v = 1'b0;
        end
        4'h9, 4'hB: begin                    // ADC, ADD
          ud    = acc + m + cin;
          sd    = $signed(acc) + $signed(m) + $signed({1'b0, cin});
          res   = ud[7:0];
          ref_c = (ud > 255);
          ref_v = (sd > 127) || (sd < -128);
        end
        default: hit = 1'b0;
      endcase
    end else if (op[7:4] inside {4'h4, 4'h5}) begin
      case (op[3:0])
        4'h0: begin
          res   = -acc;
          ref_c = (res != 8'h00);
          ref_v = (acc == 8'h80);
        end
        4'h3: begin
          res   = ~acc;
          ref_c = 1'b1;
          ref_v = 1'b0;
        end
        4'h4: begin
          res   = acc >> 1;
          ref_c = acc[0];
          ref_v = 1'b0;
        end
        4'h8: begin
          res   = acc << 1;
          ref_c = acc[7];
          ref_v = res[7] ^ acc[7];           // N xor C
        end
        4'hA: begin
          res   = acc - 8'd1;
          ref_v = (acc == 8'h80);
        end
        4'hC: begin
          res   = acc + 8'd1;
          ref_v = (acc == 8'h7F);
        end
        4'hD: begin                          // TST
          wr    = 1'b0;
          ref_v = 1'b0;
        end
        4'hF: begin
          res   = 8'h00;
          ref_c = 1'b0;
          ref_v = 1'b0;
        end
        default: hit = 1'b0;
      endcase
    end else begin
      hit = 1'b0;                            // Unknown opcode leaves the flags untouched
    end
    if (hit) begin
      ref_n = res[7];
      ref_z = (res == 8'h00);
      if (wr && (op[7:4] inside {4'hC, 4'h5})) begin
        ref_b = res;
      end else if (wr) begin
        ref_a = res;
      end
    end
  endfunction

  // --------------------------------------------------------------------------
  // One table row loaded, reset and followed on the address bus
  // --------------------------------------------------------------------------
  task automatic run_row(input int idx, input row_t r);
    addr_t pc;
    addr_t tgt;
    addr_t exp_addr;
    byte_t op;
    word_t opd;
    int    len;
    mem.delete();
    mem[16'hFFFE] = r.vector[15:8];
    mem[16'hFFFF] = r.vector[7:0];
    ref_a = 8'h00;
    ref_b = 8'h00;
    {ref_n, ref_z, ref_v, ref_c} = 4'b0;
    pc = r.vector;
    for (int i = 0; i < r.n_ins; i++) begin
      op  = r.op[i];
      opd = r.rnd ? word_t'($urandom) : r.opd[i];
      len = ins_len(op);
      mem[pc] = op;
      if (len == 2) mem[pc + 16'd1] = opd[7:0];
      if (len == 3) begin
        mem[pc + 16'd1] = opd[15:8];         // Big-endian word
        mem[pc + 16'd2] = opd[7:0];
      end
      model_exec(op, opd);
      pc = pc + 16'(len);
    end
    mem[pc]         = r.br_op;
    mem[pc + 16'd1] = r.br_off;
    tgt = branch_taken(r.br_op[3:0]) ? pc + 16'd2 + {{8{r.br_off[7]}}, r.br_off}
                                     : pc + 16'd2;
    wait_cycle();
    reset_b = 1'b0;
    repeat (5) wait_cycle();
    reset_b = 1'b1;
    check_value(addr, 16'hFFFE, $sformatf("row %0d vector high address", idx));
    wait_cycle();
    check_value(addr, 16'hFFFF, $sformatf("row %0d vector low address", idx));
    exp_addr = r.vector;
    while (exp_addr != pc + 16'd2) begin     // Program and branch bytes in order
      wait_cycle();
      check_value(addr, exp_addr, $sformatf("row %0d fetch address", idx));
      exp_addr = exp_addr + 16'd1;
    end
    wait_cycle();
    check_value(addr, tgt, $sformatf("row %0d branch target", idx));
    wait_cycle();
    check_value(addr, tgt + 16'd1, $sformatf("row %0d address after target", idx));
  endtask

  initial begin
    int unsigned seed_init;
    reset_b   = 1'b0;
    din       = 8'h00;
    seed_init = $urandom(SEED);
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i, rows[i]);
    end
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
